// ==== vlog.f ====
logic/arp_rx_pkg.sv
logic/arp_beat_if.sv
logic/arp_rx_ctrl.sv
logic/arp_field_deser.sv
logic/arp_frame_check.sv
logic/arp_rx_top.sv
dv/tb_clk_gen.sv
dv/arp_rx_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the ARP receiver testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module arp_rx_tb \
    -o arp_rx_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/arp_rx_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

// ==== dv/arp_rx_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module arp_rx_tb;

    localparam int n_directed      = 6;
    localparam int n_random        = 60;
    localparam int n_frames        = n_directed + n_random;
    localparam int watchdog_cycles = n_frames * 200 + 4;

    typedef enum logic [1:0] {
        res_good,
        res_invalid,
        res_early
    } outcome_t;

    typedef struct packed {
        outcome_t             kind;
        arp_rx_pkg::eth_hdr_t eth;
        arp_rx_pkg::arp_hdr_t arp;
    } expect_t;

    logic                              clk;
    logic                              reset;
    logic                              eth_hdr_valid;
    logic [arp_rx_pkg::mac_w-1:0]      eth_dest_mac;
    logic [arp_rx_pkg::mac_w-1:0]      eth_src_mac;
    logic [arp_rx_pkg::eth_type_w-1:0] eth_type;
    logic                              eth_hdr_ready;
    logic [7:0]                        payload_data;
    logic                              payload_valid;
    logic                              payload_last;
    logic                              payload_ready;
    logic                              out_ready;
    logic                              out_valid;
    logic [arp_rx_pkg::mac_w-1:0]      out_eth_dest_mac;
    logic [arp_rx_pkg::mac_w-1:0]      out_eth_src_mac;
    logic [arp_rx_pkg::eth_type_w-1:0] out_eth_type;
    logic [arp_rx_pkg::arp_type_w-1:0] out_arp_htype;
    logic [arp_rx_pkg::arp_type_w-1:0] out_arp_ptype;
    logic [arp_rx_pkg::arp_len_w-1:0]  out_arp_hlen;
    logic [arp_rx_pkg::arp_len_w-1:0]  out_arp_plen;
    logic [arp_rx_pkg::arp_type_w-1:0] out_arp_oper;
    logic [arp_rx_pkg::mac_w-1:0]      out_arp_sha;
    logic [arp_rx_pkg::ip_w-1:0]       out_arp_spa;
    logic [arp_rx_pkg::mac_w-1:0]      out_arp_tha;
    logic [arp_rx_pkg::ip_w-1:0]       out_arp_tpa;
    logic                              busy;
    logic                              err_invalid_hdr;
    logic                              err_early_term;

    logic [31:0]          rng          = 32'hca95;
    bit                   gaps_on      = 1'b0;
    bit                   ready_random = 1'b0;
    bit                   stall_seen   = 1'b0;
    bit                   in_payload   = 1'b0;
    int                   results_seen = 0;
    int                   frame_len;
    arp_rx_pkg::eth_hdr_t cur_eth;
    logic [7:0]           frame_bytes [0:63];
    expect_t              exp_q [$];

    tb_clk_gen clk_gen (
        .clk   (clk),
        .reset (reset)
    );

    arp_rx_top dut (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r % 32'(n));
    endfunction

    // Expected outcome from the bytes actually sent, ARP fields big-endian
    function automatic expect_t reference_outcome(input arp_rx_pkg::eth_hdr_t eth,
                                                  input logic [7:0] b [0:63],
                                                  input int count);
        expect_t r;
        r.eth       = eth;
        r.arp.htype = {b[0], b[1]};
        r.arp.ptype = {b[2], b[3]};
        r.arp.hlen  = b[4];
        r.arp.plen  = b[5];
        r.arp.oper  = {b[6], b[7]};
        r.arp.sha   = {b[8], b[9], b[10], b[11], b[12], b[13]};
        r.arp.spa   = {b[14], b[15], b[16], b[17]};
        r.arp.tha   = {b[18], b[19], b[20], b[21], b[22], b[23]};
        r.arp.tpa   = {b[24], b[25], b[26], b[27]};
        if (count < 28) begin
            r.kind = res_early;
        end else if (r.arp.hlen != arp_rx_pkg::arp_hlen_eth ||
                     r.arp.plen != arp_rx_pkg::arp_plen_ipv4) begin
            r.kind = res_invalid;
        end else begin
            r.kind = res_good;
        end
        return r;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_fields(input expect_t e);
        check_value("out_eth_dest_mac", 64'(out_eth_dest_mac), 64'(e.eth.dest_mac));
        check_value("out_eth_src_mac", 64'(out_eth_src_mac), 64'(e.eth.src_mac));
        check_value("out_eth_type", 64'(out_eth_type), 64'(e.eth.eth_type));
        check_value("out_arp_htype", 64'(out_arp_htype), 64'(e.arp.htype));
        check_value("out_arp_ptype", 64'(out_arp_ptype), 64'(e.arp.ptype));
        check_value("out_arp_hlen", 64'(out_arp_hlen), 64'(e.arp.hlen));
        check_value("out_arp_plen", 64'(out_arp_plen), 64'(e.arp.plen));
        check_value("out_arp_oper", 64'(out_arp_oper), 64'(e.arp.oper));
        check_value("out_arp_sha", 64'(out_arp_sha), 64'(e.arp.sha));
        check_value("out_arp_spa", 64'(out_arp_spa), 64'(e.arp.spa));
        check_value("out_arp_tha", 64'(out_arp_tha), 64'(e.arp.tha));
        check_value("out_arp_tpa", 64'(out_arp_tpa), 64'(e.arp.tpa));
    endtask

    // Compare against the oldest frame, retire it once the outcome is taken
    task automatic check_front(input outcome_t got, input logic consume);
        expect_t e;
        if (exp_q.size() == 0) begin
            fail_run("DUT produced an outcome with no frame outstanding");
        end else begin
            e = exp_q[0];
            check_value("outcome", 64'(got), 64'(e.kind));
            if (got == res_good) begin
                check_fields(e);
            end
            if (consume) begin
                void'(exp_q.pop_front());
                results_seen++;
            end
        end
    endtask

    task automatic make_frame(input outcome_t kind, input int pad);
        logic [31:0]  r;
        logic [111:0] eth_raw;
        for (int i = 0; i < 14; i++) begin
            r = next_rand();
            eth_raw[i*8 +: 8] = r[7:0];
        end
        cur_eth = eth_raw;
        for (int i = 0; i < 64; i++) begin
            r = next_rand();
            frame_bytes[i] = r[7:0];
        end
        // Ethernet/IPv4 ARP request or reply
        frame_bytes[0] = 8'h00;
        frame_bytes[1] = 8'h01;
        frame_bytes[2] = 8'h08;
        frame_bytes[3] = 8'h00;
        frame_bytes[4] = 8'd6;
        frame_bytes[5] = 8'd4;
        frame_bytes[6] = 8'h00;
        frame_bytes[7] = 8'(1 + rand_below(2));
        if (kind == res_invalid) begin
            case (rand_below(3))
                0: frame_bytes[4] = 8'(7 + rand_below(255));
                1: frame_bytes[5] = 8'(5 + rand_below(255));
                default: begin
                    frame_bytes[4] = 8'(7 + rand_below(255));
                    frame_bytes[5] = 8'(5 + rand_below(255));
                end
            endcase
        end
        if (kind == res_early) begin
            frame_len = 1 + rand_below(27);
        end else begin
            frame_len = 28 + pad;
        end
    endtask

    task automatic send_frame();
        exp_q.push_back(reference_outcome(cur_eth, frame_bytes, frame_len));
        eth_hdr_valid <= 1'b1;
        eth_dest_mac  <= cur_eth.dest_mac;
        eth_src_mac   <= cur_eth.src_mac;
        eth_type      <= cur_eth.eth_type;
        do begin
            @(posedge clk);
        end while (!eth_hdr_ready);
        eth_hdr_valid <= 1'b0;
        in_payload    <= 1'b1;
        for (int i = 0; i < frame_len; i++) begin
            if (gaps_on && rand_below(4) == 0) begin
                payload_valid <= 1'b0;
                repeat (1 + rand_below(3)) @(posedge clk);
            end
            payload_valid <= 1'b1;
            payload_data  <= frame_bytes[i];
            payload_last  <= (i == frame_len - 1);
            do begin
                @(posedge clk);
            end while (!payload_ready);
        end
        payload_valid <= 1'b0;
        payload_last  <= 1'b0;
        in_payload    <= 1'b0;
    endtask

    task automatic wait_results(input int count);
        wait (results_seen >= count);
        @(posedge clk);
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            // Both follow the payload phase of the frame being sent
            check_value("busy", 64'(busy), 64'(in_payload));
            check_value("payload_ready", 64'(payload_ready), 64'(in_payload));
            if (stall_seen) begin
                check_value("out_valid", 64'(out_valid), 64'd1);
            end
            stall_seen = out_valid && !out_ready;
            // Held result must keep the header port closed
            if (out_valid) begin
                check_value("eth_hdr_ready", 64'(eth_hdr_ready), 64'd0);
                check_front(res_good, out_ready);
            end
            if (err_invalid_hdr) begin
                check_front(res_invalid, 1'b1);
            end
            if (err_early_term) begin
                check_front(res_early, 1'b1);
            end
        end
    end

    initial begin : ready_driver
        int          stretch;
        logic [31:0] ready_state;
        stretch     = 0;
        ready_state = xorshift32(32'hca95 ^ 32'h5a5a0000);
        out_ready   = 1'b0;
        forever begin
            @(posedge clk);
            if (!ready_random) begin
                out_ready <= 1'b1;
            end else if (stretch == 0) begin
                ready_state = xorshift32(ready_state);
                out_ready <= ready_state[0];
                stretch = 1 + int'(ready_state[11:8]);
            end else begin
                stretch--;
            end
        end
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        fail_run($sformatf("Timeout: the test did not finish within %0d clock cycles",
                           watchdog_cycles));
    end

    initial begin
        eth_hdr_valid = 1'b0;
        eth_dest_mac  = '0;
        eth_src_mac   = '0;
        eth_type      = '0;
        payload_data  = 8'h00;
        payload_valid = 1'b0;
        payload_last  = 1'b0;
        do begin
            @(posedge clk);
        end while (reset !== 1'b0);

        // Directed frames with the output always ready
        make_frame(res_good, 0);
        send_frame();
        make_frame(res_invalid, 0);
        send_frame();
        make_frame(res_early, 0);
        send_frame();
        // One byte short of a full header
        make_frame(res_good, 0);
        frame_len = 27;
        send_frame();
        // Same frame unpadded and then padded
        make_frame(res_good, 0);
        send_frame();
        frame_len = 28 + 9;
        send_frame();
        wait_results(n_directed);

        // Back-to-back random frames with gaps and output stalls
        gaps_on      = 1'b1;
        ready_random <= 1'b1;
        for (int i = 0; i < n_random; i++) begin
            case (rand_below(4))
                0: make_frame(res_invalid, rand_below(17));
                1: make_frame(res_early, 0);
                default: make_frame(res_good, rand_below(17));
            endcase
            repeat (rand_below(3)) @(posedge clk);
            send_frame();
        end
        wait_results(n_frames);
        repeat (4) @(posedge clk);

        if (exp_q.size() != 0) begin
            fail_run("Frames were still waiting for an outcome at the end of the run");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic reset
);

    localparam int reset_cycles = 4;

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== logic/arp_rx_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module arp_rx_top (
    input  logic                              clk,
    input  logic                              reset,
    // Ethernet header port
    input  logic                              eth_hdr_valid,
    input  logic [arp_rx_pkg::mac_w-1:0]      eth_dest_mac,
    input  logic [arp_rx_pkg::mac_w-1:0]      eth_src_mac,
    input  logic [arp_rx_pkg::eth_type_w-1:0] eth_type,
    output logic                              eth_hdr_ready,
    // Payload byte stream
    input  logic [7:0]                        payload_data,
    input  logic                              payload_valid,
    input  logic                              payload_last,
    output logic                              payload_ready,
    // Decoded frame
    input  logic                              out_ready,
    output logic                              out_valid,
    output logic [arp_rx_pkg::mac_w-1:0]      out_eth_dest_mac,
    output logic [arp_rx_pkg::mac_w-1:0]      out_eth_src_mac,
    output logic [arp_rx_pkg::eth_type_w-1:0] out_eth_type,
    output logic [arp_rx_pkg::arp_type_w-1:0] out_arp_htype,
    output logic [arp_rx_pkg::arp_type_w-1:0] out_arp_ptype,
    output logic [arp_rx_pkg::arp_len_w-1:0]  out_arp_hlen,
    output logic [arp_rx_pkg::arp_len_w-1:0]  out_arp_plen,
    output logic [arp_rx_pkg::arp_type_w-1:0] out_arp_oper,
    output logic [arp_rx_pkg::mac_w-1:0]      out_arp_sha,
    output logic [arp_rx_pkg::ip_w-1:0]       out_arp_spa,
    output logic [arp_rx_pkg::mac_w-1:0]      out_arp_tha,
    output logic [arp_rx_pkg::ip_w-1:0]       out_arp_tpa,
    // Status
    output logic                              busy,
    output logic                              err_invalid_hdr,
    output logic                              err_early_term
);

    arp_rx_pkg::eth_hdr_t eth_hdr_in;
    arp_rx_pkg::eth_hdr_t eth_hdr_out;
    arp_rx_pkg::arp_hdr_t arp_hdr_raw;
    arp_rx_pkg::arp_hdr_t arp_hdr_out;
    logic                 frame_end;
    logic                 complete;
    logic                 result_done;

    arp_beat_if beat_bus ();

    assign eth_hdr_in.dest_mac = eth_dest_mac;
    assign eth_hdr_in.src_mac  = eth_src_mac;
    assign eth_hdr_in.eth_type = eth_type;

    arp_rx_ctrl u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .eth_hdr_valid (eth_hdr_valid),
        .eth_hdr_in    (eth_hdr_in),
        .eth_hdr_ready (eth_hdr_ready),
        .payload_data  (payload_data),
        .payload_valid (payload_valid),
        .payload_last  (payload_last),
        .payload_ready (payload_ready),
        .beat_out      (beat_bus),
        .out_valid     (out_valid),
        .result_done   (result_done),
        .eth_hdr_out   (eth_hdr_out),
        .busy          (busy)
    );

    arp_field_deser u_deser (
        .clk       (clk),
        .reset     (reset),
        .beat_in   (beat_bus),
        .frame_end (frame_end),
        .complete  (complete),
        .arp_hdr   (arp_hdr_raw)
    );

    arp_frame_check u_check (
        .clk             (clk),
        .reset           (reset),
        .frame_end       (frame_end),
        .complete        (complete),
        .arp_hdr_in      (arp_hdr_raw),
        .out_ready       (out_ready),
        .out_valid       (out_valid),
        .arp_hdr_out     (arp_hdr_out),
        .err_invalid_hdr (err_invalid_hdr),
        .err_early_term  (err_early_term),
        .result_done     (result_done)
    );

    assign out_eth_dest_mac = eth_hdr_out.dest_mac;
    assign out_eth_src_mac  = eth_hdr_out.src_mac;
    assign out_eth_type     = eth_hdr_out.eth_type;

    assign out_arp_htype = arp_hdr_out.htype;
    assign out_arp_ptype = arp_hdr_out.ptype;
    assign out_arp_hlen  = arp_hdr_out.hlen;
    assign out_arp_plen  = arp_hdr_out.plen;
    assign out_arp_oper  = arp_hdr_out.oper;
    assign out_arp_sha   = arp_hdr_out.sha;
    assign out_arp_spa   = arp_hdr_out.spa;
    assign out_arp_tha   = arp_hdr_out.tha;
    assign out_arp_tpa   = arp_hdr_out.tpa;

endmodule

`default_nettype wire

// ==== logic/arp_frame_check.sv ====
`timescale 1ns/10ps
`default_nettype none

module arp_frame_check (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 frame_end,
    input  logic                 complete,
    input  arp_rx_pkg::arp_hdr_t arp_hdr_in,
    input  logic                 out_ready,
    output logic                 out_valid,
    output arp_rx_pkg::arp_hdr_t arp_hdr_out,
    output logic                 err_invalid_hdr,
    output logic                 err_early_term,
    output logic                 result_done
);

    logic len_ok;
    logic accept;

    // Ethernet hardware addresses and IPv4 protocol addresses only
    assign len_ok = (arp_hdr_in.hlen == arp_rx_pkg::arp_hlen_eth) &&
                    (arp_hdr_in.plen == arp_rx_pkg::arp_plen_ipv4);

    assign accept = frame_end && complete && len_ok;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid       <= 1'b0;
            err_invalid_hdr <= 1'b0;
            err_early_term  <= 1'b0;
            result_done     <= 1'b0;
        end else begin
            result_done     <= frame_end;
            err_early_term  <= frame_end && !complete;
            err_invalid_hdr <= frame_end && complete && !len_ok;
            if (accept) begin
                out_valid <= 1'b1;
            end else if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // Holding register, only loaded by a good frame
    always_ff @(posedge clk) begin
        if (accept) begin
            arp_hdr_out <= arp_hdr_in;
        end
    end

    a_err_excl: assert property (
        @(posedge clk) disable iff (reset)
        !(err_invalid_hdr && err_early_term)
    );

    a_out_hold: assert property (
        @(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> out_valid && $stable(arp_hdr_out)
    );

endmodule

`default_nettype wire

// ==== logic/arp_field_deser.sv ====
`timescale 1ns/10ps
`default_nettype none

module arp_field_deser (
    input  logic                 clk,
    input  logic                 reset,
    arp_beat_if.deser            beat_in,
    output logic                 frame_end,
    output logic                 complete,
    output arp_rx_pkg::arp_hdr_t arp_hdr
);

    logic [arp_rx_pkg::arp_ptr_w-1:0]          ptr_q;
    logic [arp_rx_pkg::arp_hdr_bytes-1:0][7:0] byte_q;
    logic [arp_rx_pkg::arp_ptr_w-1:0]          byte_idx;
    logic                                      ptr_full;
    logic                                      take_byte;

    // All 28 header bytes seen
    assign ptr_full  = (ptr_q == arp_rx_pkg::arp_hdr_bytes);
    assign complete  = ptr_full;
    assign take_byte = beat_in.beat && !ptr_full;

    // First byte on the wire lands in the top slot
    assign byte_idx = arp_rx_pkg::arp_hdr_bytes - 1'b1 - ptr_q;

    assign arp_hdr = byte_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr_q <= '0;
        end else if (beat_in.start) begin
            ptr_q <= '0;
        end else if (take_byte) begin
            ptr_q <= ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            frame_end <= 1'b0;
        end else begin
            frame_end <= beat_in.beat && beat_in.last;
        end
    end

    // Padding beyond byte 28 is dropped
    always_ff @(posedge clk) begin
        if (take_byte) begin
            byte_q[byte_idx] <= beat_in.data;
        end
    end

    a_no_beat_after_last: assert property (
        @(posedge clk) disable iff (reset)
        (beat_in.beat && beat_in.last) |=> !beat_in.beat
    );

endmodule

`default_nettype wire

// ==== logic/arp_rx_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module arp_rx_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 eth_hdr_valid,
    input  arp_rx_pkg::eth_hdr_t eth_hdr_in,
    output logic                 eth_hdr_ready,
    input  logic [7:0]           payload_data,
    input  logic                 payload_valid,
    input  logic                 payload_last,
    output logic                 payload_ready,
    arp_beat_if.ctrl             beat_out,
    input  logic                 out_valid,
    input  logic                 result_done,
    output arp_rx_pkg::eth_hdr_t eth_hdr_out,
    output logic                 busy
);

    typedef enum logic [1:0] {
        st_header,
        st_payload,
        st_wait
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   hdr_fire;
    logic   beat_fire;

    assign hdr_fire  = eth_hdr_valid && eth_hdr_ready;
    assign beat_fire = payload_valid && payload_ready;

    // Accepted beats go straight to the deserializer
    assign beat_out.start = hdr_fire;
    assign beat_out.beat  = beat_fire;
    assign beat_out.data  = payload_data;
    assign beat_out.last  = payload_last;

    assign busy = (state_q == st_payload);

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_header: begin
                if (hdr_fire) begin
                    state_d = st_payload;
                end
            end
            st_payload: begin
                if (beat_fire && payload_last) begin
                    state_d = st_wait;
                end
            end
            st_wait: begin
                // Checker has produced its outcome for this frame
                if (result_done) begin
                    state_d = st_header;
                end
            end
            default: begin
                state_d = st_header;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q       <= st_header;
            eth_hdr_ready <= 1'b1;
            payload_ready <= 1'b0;
        end else begin
            state_q       <= state_d;
            // Header port stays shut while a result waits to be taken
            eth_hdr_ready <= (state_d == st_header) && !out_valid;
            payload_ready <= (state_d == st_payload);
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_fire) begin
            eth_hdr_out <= eth_hdr_in;
        end
    end

    a_ready_excl: assert property (
        @(posedge clk) disable iff (reset)
        !(eth_hdr_ready && payload_ready)
    );

endmodule

`default_nettype wire

// ==== logic/arp_beat_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface arp_beat_if;

    // Header accepted, restart byte collection
    logic       start;
    // One accepted payload byte
    logic       beat;
    logic [7:0] data;
    logic       last;

    modport ctrl (
        output start,
        output beat,
        output data,
        output last
    );

    modport deser (
        input start,
        input beat,
        input data,
        input last
    );

endinterface

`default_nettype wire

// ==== logic/arp_rx_pkg.sv ====
`default_nettype none

package arp_rx_pkg;

    // Ethernet and IPv4 address widths
    localparam int mac_w      = 48;
    localparam int eth_type_w = 16;
    localparam int ip_w       = 32;

    // ARP type and length field widths
    localparam int arp_type_w = 16;
    localparam int arp_len_w  = 8;

    // Byte pointer into the ARP header, saturates at the header size
    localparam int arp_ptr_w = 5;
    localparam logic [arp_ptr_w-1:0] arp_hdr_bytes = 5'd28;

    // Only Ethernet hardware addresses and IPv4 protocol addresses are accepted
    localparam logic [arp_len_w-1:0] arp_hlen_eth  = 8'd6;
    localparam logic [arp_len_w-1:0] arp_plen_ipv4 = 8'd4;

    typedef struct packed {
        logic [mac_w-1:0]      dest_mac;
        logic [mac_w-1:0]      src_mac;
        logic [eth_type_w-1:0] eth_type;
    } eth_hdr_t;

    // Fields in wire order, first byte on the wire is the MSB
    typedef struct packed {
        logic [arp_type_w-1:0] htype;
        logic [arp_type_w-1:0] ptype;
        logic [arp_len_w-1:0]  hlen;
        logic [arp_len_w-1:0]  plen;
        logic [arp_type_w-1:0] oper;
        logic [mac_w-1:0]      sha;
        logic [ip_w-1:0]       spa;
        logic [mac_w-1:0]      tha;
        logic [ip_w-1:0]       tpa;
    } arp_hdr_t;

endpackage

`default_nettype wire
